// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_mem_stage
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed
FAIL_MSG  = Checks failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dmem_byte_bank.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module dmem_byte_bank #(
	parameter int DEPTH = `DMEM_DEPTH
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] index,
	input  logic [7:0]               wdata,
	output logic [7:0]               rdata
);

	logic [7:0] mem [DEPTH];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[index] <= wdata;
		end
	end

	// read data holds between accepts
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[index];
		end
	end

endmodule

// ==== load_lane_extract.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module load_lane_extract
	import mem_stage_pkg::*;
(
	input  xlen_t      bank_data,
	input  logic       is_load,
	input  mem_funct_t funct,
	input  logic [2:0] offset,
	input  xlen_t      alu_result,
	output xlen_t      wb_data
);

	localparam int XLEN = `DMEM_XLEN;

	xlen_t      field;
	logic [5:0] bit_shift;
	xlen_t      load_data;

	assign bit_shift = {offset, 3'b000};

	// addressed byte moves down to bit 0
	assign field = bank_data >> bit_shift;

	always_comb begin
		case (funct)
			FUNCT_B: begin
				load_data = {{(XLEN-8){field[7]}}, field[7:0]};
			end
			FUNCT_H: begin
				load_data = {{(XLEN-16){field[15]}}, field[15:0]};
			end
			FUNCT_W: begin
				load_data = {{(XLEN-32){field[31]}}, field[31:0]};
			end
			FUNCT_D: begin
				load_data = field;
			end
			FUNCT_BU: begin
				load_data = {{(XLEN-8){1'b0}}, field[7:0]};
			end
			FUNCT_HU: begin
				load_data = {{(XLEN-16){1'b0}}, field[15:0]};
			end
			FUNCT_WU: begin
				load_data = {{(XLEN-32){1'b0}}, field[31:0]};
			end
			default: begin
				load_data = '0; // 3'b111
			end
		endcase
	end

	// everything that is not a load writes back the alu result
	assign wb_data = is_load ? load_data : alu_result;

endmodule

// ==== mem_pipe_ctrl.sv ====
`timescale 1ns/1ps

module mem_pipe_ctrl
	import mem_stage_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	output logic        in_ready,
	output logic        accept,
	input  xlen_t       pc,
	input  logic [31:0] ins,
	input  logic        is_load,
	input  logic        reg_w_en,
	input  logic [4:0]  rd,
	input  xlen_t       alu_result,
	input  logic        out_ready,
	output logic        out_valid,
	output xlen_t       out_pc,
	output logic [31:0] out_ins,
	output logic        out_reg_w_en,
	output logic [4:0]  out_rd,
	output logic        out_is_load,
	output xlen_t       out_alu_result
);

	// room when empty or when the entry leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0; // drained, nothing new
		end
	end

	// payload only moves on a transfer, so it holds while stalled
	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc         <= pc;
			out_ins        <= ins;
			out_reg_w_en   <= reg_w_en;
			out_rd         <= rd;
			out_is_load    <= is_load;
			out_alu_result <= alu_result;
		end
	end

endmodule

// ==== mem_stage_cfg.svh ====
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// data path width of the stage, also the memory word width
`define DMEM_XLEN 64

// words per byte bank, 512 x 8 bytes = 4 KiB in total
`define DMEM_DEPTH 512

// byte address that maps to memory word 0
`define DMEM_BASE 64'h0000_0000_8000_0000

`endif

// ==== mem_stage_pkg.sv ====
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

	// one data word, register and memory width
	typedef logic [`DMEM_XLEN-1:0] xlen_t;

	// one write enable per byte lane
	typedef logic [`DMEM_XLEN/8-1:0] lane_mask_t;

	// funct3 of loads and stores, 3'b111 has no meaning
	typedef enum logic [2:0] {
		FUNCT_B  = 3'b000, // lb / sb
		FUNCT_H  = 3'b001, // lh / sh
		FUNCT_W  = 3'b010, // lw / sw
		FUNCT_D  = 3'b011, // ld / sd
		FUNCT_BU = 3'b100, // lbu
		FUNCT_HU = 3'b101, // lhu
		FUNCT_WU = 3'b110  // lwu
	} mem_funct_t;

endpackage

// ==== mem_stage_top.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_stage_top
	import mem_stage_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        in_valid,
	output logic        in_ready,
	input  xlen_t       pc,
	input  logic [31:0] ins,
	input  logic        is_load,
	input  logic        is_store,
	input  logic        reg_w_en,
	input  logic [4:0]  rd,
	input  xlen_t       rs2_data,
	input  xlen_t       alu_result,
	input  logic        out_ready,
	output logic        out_valid,
	output xlen_t       out_pc,
	output logic [31:0] out_ins,
	output logic        out_reg_w_en,
	output logic [4:0]  out_rd,
	output xlen_t       wb_data
);

	localparam int DEPTH = `DMEM_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int LANES = `DMEM_XLEN / 8;

	logic             accept;
	logic             out_is_load;
	xlen_t            out_alu_result;
	xlen_t            byte_addr;
	logic [IDX_W-1:0] mem_index;
	lane_mask_t       lane_we;
	xlen_t            lane_data;
	xlen_t            bank_data;

	// word index wraps modulo the depth
	assign byte_addr = alu_result - xlen_t'(`DMEM_BASE);
	assign mem_index = byte_addr[IDX_W+2:3];

	mem_pipe_ctrl ctrl_i (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.accept         (accept),
		.pc             (pc),
		.ins            (ins),
		.is_load        (is_load),
		.reg_w_en       (reg_w_en),
		.rd             (rd),
		.alu_result     (alu_result),
		.out_ready      (out_ready),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_ins        (out_ins),
		.out_reg_w_en   (out_reg_w_en),
		.out_rd         (out_rd),
		.out_is_load    (out_is_load),
		.out_alu_result (out_alu_result)
	);

	store_lane_steer steer_i (
		.accept    (accept),
		.is_store  (is_store),
		.funct     (mem_funct_t'(ins[14:12])),
		.offset    (alu_result[2:0]),
		.rs2_data  (rs2_data),
		.lane_we   (lane_we),
		.lane_data (lane_data)
	);

	// one bank per byte lane, all share the word index
	for (genvar i = 0; i < LANES; i++) begin : g_bank
		dmem_byte_bank #(
			.DEPTH (DEPTH)
		) bank_i (
			.clk   (clk),
			.en    (accept),
			.we    (lane_we[i]),
			.index (mem_index),
			.wdata (lane_data[8*i +: 8]),
			.rdata (bank_data[8*i +: 8])
		);
	end

	// decode uses the registered copy, aligned with bank read data
	load_lane_extract extract_i (
		.bank_data  (bank_data),
		.is_load    (out_is_load),
		.funct      (mem_funct_t'(out_ins[14:12])),
		.offset     (out_alu_result[2:0]),
		.alu_result (out_alu_result),
		.wb_data    (wb_data)
	);

endmodule

// ==== sources.f ====
+incdir+.
mem_stage_pkg.sv
store_lane_steer.sv
dmem_byte_bank.sv
load_lane_extract.sv
mem_pipe_ctrl.sv
mem_stage_top.sv
tb_clock_gen.sv
tb_mem_stage.sv

// ==== store_lane_steer.sv ====
`timescale 1ns/1ps

module store_lane_steer
	import mem_stage_pkg::*;
(
	input  logic       accept,
	input  logic       is_store,
	input  mem_funct_t funct,
	input  logic [2:0] offset,
	input  xlen_t      rs2_data,
	output lane_mask_t lane_we,
	output xlen_t      lane_data
);

	lane_mask_t size_mask;
	logic [5:0] bit_shift;

	// bytes covered by the store, before placing at the offset
	always_comb begin
		case (funct)
			FUNCT_B: size_mask = lane_mask_t'(8'h01);
			FUNCT_H: size_mask = lane_mask_t'(8'h03);
			FUNCT_W: size_mask = lane_mask_t'(8'h0f);
			FUNCT_D: size_mask = lane_mask_t'(8'hff);
			default: size_mask = '0; // no such store
		endcase
	end

	assign bit_shift = {offset, 3'b000};

	// only a handshaked store may touch the banks
	always_comb begin
		if (accept && is_store) begin
			lane_we = size_mask << offset;
		end else begin
			lane_we = '0;
		end
	end

	// low bytes of rs2 move up to the addressed lanes
	assign lane_data = rs2_data << bit_shift;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk; // 8 ns period
	end

	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0; // released on a rising edge
	end

endmodule

// ==== tb_mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module tb_mem_stage
	import mem_stage_pkg::*;
();

	localparam int DEPTH     = `DMEM_DEPTH;
	localparam int IDX_W     = $clog2(DEPTH);
	localparam int MEM_BYTES = DEPTH * 8;
	localparam int NUM_OPS   = 2000;
	localparam int TIMEOUT   = 1000;

	typedef struct packed {
		xlen_t       pc;
		logic [31:0] ins;
		logic [4:0]  rd;
		logic        reg_w_en;
		xlen_t       wb_data;
	} expect_t;

	logic        clk;
	logic        reset;
	logic        in_valid;
	logic        in_ready;
	xlen_t       pc;
	logic [31:0] ins;
	logic        is_load;
	logic        is_store;
	logic        reg_w_en;
	logic [4:0]  rd;
	xlen_t       rs2_data;
	xlen_t       alu_result;
	logic        out_ready;
	logic        out_valid;
	xlen_t       out_pc;
	logic [31:0] out_ins;
	logic        out_reg_w_en;
	logic [4:0]  out_rd;
	xlen_t       wb_data;

	logic [7:0]  shadow_mem [MEM_BYTES];
	expect_t     exp_q [$];
	logic [31:0] lfsr_state = 32'hd32ce3aa;
	logic        reset_prev = 1'b0;
	logic        stalled = 1'b0;

	tb_clock_gen clock_i (
		.clk   (clk),
		.reset (reset)
	);

	mem_stage_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.pc           (pc),
		.ins          (ins),
		.is_load      (is_load),
		.is_store     (is_store),
		.reg_w_en     (reg_w_en),
		.rd           (rd),
		.rs2_data     (rs2_data),
		.alu_result   (alu_result),
		.out_ready    (out_ready),
		.out_valid    (out_valid),
		.out_pc       (out_pc),
		.out_ins      (out_ins),
		.out_reg_w_en (out_reg_w_en),
		.out_rd       (out_rd),
		.wb_data      (wb_data)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[62:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic int size_of(input logic [2:0] funct);
		return 1 << funct[1:0]; // b h w d
	endfunction

	function automatic xlen_t word_addr(input int word, input logic [2:0] offset);
		return xlen_t'(`DMEM_BASE) + xlen_t'(word) * 8 + xlen_t'(offset);
	endfunction

	task automatic stop_on_failure();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
			stop_on_failure();
		end
	endtask

	// field assembled byte by byte, then extended
	function automatic xlen_t load_value(input int base, input logic [2:0] funct);
		int    size;
		xlen_t v;
		if (funct == 3'b111) begin
			return '0;
		end
		size = size_of(funct);
		v = '0;
		for (int i = 0; i < size; i++) begin
			v[8*i +: 8] = shadow_mem[base + i];
		end
		if (!funct[2] && size < 8 && v[8*size-1]) begin
			for (int i = size; i < 8; i++) begin
				v[8*i +: 8] = 8'hff;
			end
		end
		return v;
	endfunction

	task automatic store_bytes(input int base, input logic [2:0] funct, input xlen_t data);
		int size;
		size = size_of(funct);
		if (!funct[2]) begin // 100 and up write nothing
			for (int i = 0; i < size; i++) begin
				shadow_mem[base + i] = data[8*i +: 8];
			end
		end
	endtask

	task automatic model_accept();
		expect_t e;
		xlen_t   offs;
		int      base;
		offs = alu_result - xlen_t'(`DMEM_BASE);
		base = int'(offs[IDX_W+2:0]);
		e.pc       = pc;
		e.ins      = ins;
		e.rd       = rd;
		e.reg_w_en = reg_w_en;
		e.wb_data  = is_load ? load_value(base, ins[14:12]) : alu_result;
		if (is_store) begin
			store_bytes(base, ins[14:12], rs2_data);
		end
		exp_q.push_back(e);
	endtask

	task automatic compare_front();
		expect_t e;
		if (exp_q.size() == 0) begin
			$display("out_valid high at %0t with no accepted operation outstanding", $time);
			stop_on_failure();
		end else begin
			e = exp_q[0];
			check_value("out_pc", e.pc, out_pc);
			check_value("out_ins", 64'(e.ins), 64'(out_ins));
			check_value("out_rd", 64'(e.rd), 64'(out_rd));
			check_value("out_reg_w_en", 64'(e.reg_w_en), 64'(out_reg_w_en));
			check_value("wb_data", e.wb_data, wb_data);
		end
	endtask

	// sampled mid-cycle, inputs only move on the rising edge
	always @(negedge clk) begin
		if (reset || reset_prev) begin
			check_value("out_valid", 64'd0, 64'(out_valid));
			check_value("in_ready", 64'd1, 64'(in_ready));
		end
		reset_prev = reset;
		if (!reset) begin
			if (stalled) begin
				check_value("out_valid", 64'd1, 64'(out_valid)); // must hold under stall
			end
			check_value("in_ready", 64'(exp_q.size() == 0 || out_ready), 64'(in_ready));
			if (out_valid) begin
				compare_front();
			end
			stalled = out_valid && !out_ready;
			if (out_valid && out_ready) begin
				void'(exp_q.pop_front());
			end
			if (in_valid && in_ready) begin
				model_accept();
			end
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		out_ready <= rand_bits(2) != 64'd0; // ready three cycles in four
	endtask

	task automatic offer_op(
		input logic       load,
		input logic       store,
		input xlen_t      alu,
		input logic [2:0] funct,
		input xlen_t      src
	);
		int          idle;
		int          waited;
		logic [31:0] ins_word;
		idle = 0;
		if (rand_bits(2) == 64'd0) begin
			idle = int'(rand_bits(2)) + 1;
		end
		for (int i = 0; i < idle; i++) begin
			step_cycle();
			in_valid <= 1'b0;
		end
		step_cycle();
		ins_word = 32'(rand_bits(32));
		ins_word[14:12] = funct;
		in_valid   <= 1'b1;
		pc         <= rand_bits(64);
		ins        <= ins_word;
		is_load    <= load;
		is_store   <= store;
		reg_w_en   <= 1'(rand_bits(1));
		rd         <= 5'(rand_bits(5));
		rs2_data   <= src;
		alu_result <= alu;
		waited = 0;
		@(negedge clk);
		while (!in_ready) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: operation not accepted within %0d cycles", TIMEOUT);
				stop_on_failure();
			end
			step_cycle();
			@(negedge clk);
		end
	endtask

	initial begin
		int         waited;
		logic [1:0] kind;
		logic [2:0] funct;
		logic [2:0] offset;
		xlen_t      addr;
		xlen_t      alu;
		xlen_t      src;
		in_valid   <= 1'b0;
		pc         <= '0;
		ins        <= '0;
		is_load    <= 1'b0;
		is_store   <= 1'b0;
		reg_w_en   <= 1'b0;
		rd         <= '0;
		rs2_data   <= '0;
		alu_result <= '0;
		out_ready  <= 1'b0;
		waited = 0;
		@(posedge clk);
		while (reset) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: reset never released");
				stop_on_failure();
			end
			@(posedge clk);
		end

		// fill every word so later loads have known data
		for (int w = 0; w < DEPTH; w++) begin
			src = rand_bits(64);
			offer_op(1'b0, 1'b1, word_addr(w, 3'd0), 3'b011, src);
		end

		for (int n = 0; n < NUM_OPS; n++) begin
			kind   = 2'(rand_bits(2));
			funct  = 3'(rand_bits(3));
			offset = 3'(rand_bits(3));
			offset = offset & ~(3'(size_of(funct)) - 3'd1); // natural alignment
			addr   = word_addr(int'(rand_bits(IDX_W)), offset);
			alu    = rand_bits(64);
			src    = rand_bits(64);
			case (kind)
				2'd0: offer_op(1'b0, 1'b0, alu, funct, src);
				2'd1: offer_op(1'b0, 1'b1, addr, funct, src);
				default: offer_op(1'b1, 1'b0, addr, funct, src);
			endcase
		end

		@(posedge clk);
		in_valid  <= 1'b0;
		out_ready <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (out_valid) begin
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: output register never drained");
				stop_on_failure();
			end
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		if (exp_q.size() == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			check_value("scoreboard entries left", 64'd0, 64'(exp_q.size()));
		end
	end

endmodule
